// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_sgd_l1_update
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/fp_compare.sv ====
`default_nettype none

module fp_compare import l1_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  fp32_t a,
    input  fp32_t b,
    input  logic  in_valid,
    output logic  gt,
    output logic  lt,
    output logic  q_valid
);

    // x > y on sign and magnitude, +0 and -0 compare equal
    function automatic logic greater(input fp32_t x, input fp32_t y);
        logic [30:0] mx, my;
        mx = (x.exponent == 8'd0) ? 31'd0 : {x.exponent, x.mantissa};
        my = (y.exponent == 8'd0) ? 31'd0 : {y.exponent, y.mantissa};
        if (mx == 31'd0 && my == 31'd0) begin
            return 1'b0;
        end
        if (x.sign != y.sign) begin
            return !x.sign;
        end
        return x.sign ? (mx < my) : (mx > my);
    endfunction

    fp32_t b_neg;

    assign b_neg = '{sign: ~b.sign, exponent: b.exponent, mantissa: b.mantissa};

    always_ff @(posedge clk) begin
        gt <= greater(a, b);
        lt <= greater(b_neg, a); // a < -b, lower edge of the dead zone
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/fp_sub.sv ====
`default_nettype none

module fp_sub import l1_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  fp32_t a,
    input  fp32_t b,
    input  logic  in_valid,
    output fp32_t q,
    output logic  q_valid
);

    function automatic logic [4:0] lzc28(input logic [27:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd28;
        found = 1'b0;
        for (int i = 27; i >= 0; i--) begin
            if (v[i] && !found) begin
                n     = 5'(27 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // stage 1 negates b, orders by magnitude and aligns the smaller one
    logic [30:0] mag_a, mag_b;
    logic        sign_bn;
    logic        swap;
    logic        s_big, s_sml;
    logic [7:0]  e_big, e_sml, e_diff;
    logic [23:0] m_big, m_sml;
    logic [4:0]  shamt;
    logic [53:0] sh_w;

    always_comb begin
        mag_a   = (a.exponent == 8'd0) ? 31'd0 : {a.exponent, a.mantissa}; // flush denormals
        mag_b   = (b.exponent == 8'd0) ? 31'd0 : {b.exponent, b.mantissa};
        sign_bn = ~b.sign;
        swap    = mag_b > mag_a;
        s_big   = swap ? sign_bn : a.sign;
        s_sml   = swap ? a.sign : sign_bn;
        e_big   = swap ? mag_b[30:23] : mag_a[30:23];
        e_sml   = swap ? mag_a[30:23] : mag_b[30:23];
        m_big   = swap ? {|mag_b[30:23], mag_b[22:0]} : {|mag_a[30:23], mag_a[22:0]};
        m_sml   = swap ? {|mag_a[30:23], mag_a[22:0]} : {|mag_b[30:23], mag_b[22:0]};
        e_diff  = e_big - e_sml;
        shamt   = (e_diff > 8'd27) ? 5'd27 : e_diff[4:0];
        sh_w    = {m_sml, 3'b000, 27'd0} >> shamt; // low half collects sticky
    end

    logic        s1_sign;
    logic [7:0]  s1_exp;
    logic [26:0] s1_mx, s1_my;
    logic        s1_sub;

    always_ff @(posedge clk) begin
        s1_sign <= s_big;
        s1_exp  <= e_big;
        s1_mx   <= {m_big, 3'b000};
        s1_my   <= {sh_w[53:28], sh_w[27] | (|sh_w[26:0])};
        s1_sub  <= s_big ^ s_sml;
    end

    // stage 2 adds or subtracts the magnitudes and counts leading zeros
    logic [27:0] sum;

    assign sum = s1_sub ? ({1'b0, s1_mx} - {1'b0, s1_my}) : ({1'b0, s1_mx} + {1'b0, s1_my});

    logic        s2_sign;
    logic [7:0]  s2_exp;
    logic [27:0] s2_sum;
    logic [4:0]  s2_lz;

    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_exp  <= s1_exp;
        s2_sum  <= sum;
        s2_lz   <= lzc28(sum);
    end

    // stage 3 puts the msb at bit 27 and rounds to nearest even
    logic [27:0]       norm;
    logic              round_up;
    logic [23:0]       mant_r;
    logic signed [9:0] exp_n, exp_f;
    fp32_t             res;

    always_comb begin
        norm     = s2_sum << s2_lz;
        round_up = norm[3] & ((|norm[2:0]) | norm[4]);
        mant_r   = {1'b0, norm[26:4]} + 24'(round_up);
        exp_n    = $signed({2'b00, s2_exp}) + 10'sd1 - $signed({5'b00000, s2_lz});
        exp_f    = exp_n + $signed({9'd0, mant_r[23]}); // mantissa overflow bumps exponent
        if (s2_sum == 28'd0 || exp_f <= 10'sd0) begin
            res = '0; // exact zero and underflow both give +0
        end else begin
            res.sign     = s2_sign;
            res.exponent = exp_f[7:0];
            res.mantissa = mant_r[22:0]; // wraps to zero on overflow
        end
    end

    always_ff @(posedge clk) begin
        q <= res;
    end

    logic [SUB_LAT-1:0] vld_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[SUB_LAT-2:0], in_valid};
        end
    end

    assign q_valid = vld_q[SUB_LAT-1];

endmodule

`default_nettype wire

// ==== source/l1_pkg.sv ====
`default_nettype none

package l1_pkg;

    // ieee single precision, denormals flushed
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp32_t;

    typedef logic [9:0] idx_t;

    // one input beat, 106 bits
    typedef struct packed {
        fp32_t model;
        fp32_t step;
        fp32_t lambda;
        idx_t  idx;
    } l1_req_t;

    // one output beat, 42 bits
    typedef struct packed {
        fp32_t new_model;
        idx_t  idx;
    } l1_resp_t;

    // candidate corrections, travel together to the select stage
    typedef struct packed {
        fp32_t plus_lambda;
        fp32_t minus_lambda;
    } step_pair_t;

    localparam int SUB_LAT  = 3;
    localparam int CMP_LAT  = 1;
    localparam int PROX_LAT = SUB_LAT + CMP_LAT + 1;
    localparam int UPD_LAT  = PROX_LAT + SUB_LAT;

endpackage

`default_nettype wire

// ==== source/l1_prox_step.sv ====
`default_nettype none

module l1_prox_step import l1_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  fp32_t model,
    input  fp32_t step,
    input  fp32_t lambda,
    input  logic  in_valid,
    output fp32_t corr,
    output logic  out_valid
);

    fp32_t neg_lambda;

    assign neg_lambda = '{sign: ~lambda.sign, exponent: lambda.exponent,
                          mantissa: lambda.mantissa};

    fp32_t diff;
    logic  diff_valid;
    fp32_t step_plus, step_minus;

    fp_sub i_diff_sub (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (model),
        .b        (step),
        .in_valid (in_valid),
        .q        (diff),
        .q_valid  (diff_valid)
    );

    fp_sub i_plus_sub ( // step - (-lambda)
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (step),
        .b        (neg_lambda),
        .in_valid (in_valid),
        .q        (step_plus),
        .q_valid  ()
    );

    fp_sub i_minus_sub (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (step),
        .b        (lambda),
        .in_valid (in_valid),
        .q        (step_minus),
        .q_valid  ()
    );

    // lambda has to meet diff at the comparator
    fp32_t lambda_d;

    pipe_delay #(.payload_t(fp32_t), .depth(SUB_LAT)) i_lambda_dly (
        .clk (clk),
        .d   (lambda),
        .q   (lambda_d)
    );

    logic gt, lt, cmp_valid;

    fp_compare i_cmp (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (diff),
        .b        (lambda_d),
        .in_valid (diff_valid),
        .gt       (gt),
        .lt       (lt),
        .q_valid  (cmp_valid)
    );

    step_pair_t pair_d;
    fp32_t      model_d;

    pipe_delay #(.payload_t(step_pair_t), .depth(CMP_LAT)) i_pair_dly (
        .clk (clk),
        .d   ('{plus_lambda: step_plus, minus_lambda: step_minus}),
        .q   (pair_d)
    );

    pipe_delay #(.payload_t(fp32_t), .depth(SUB_LAT + CMP_LAT)) i_model_dly (
        .clk (clk),
        .d   (model),
        .q   (model_d)
    );

    always_ff @(posedge clk) begin
        if (gt) begin
            corr <= pair_d.plus_lambda;
        end else if (lt) begin
            corr <= pair_d.minus_lambda;
        end else begin
            corr <= model_d; // dead zone, model - corr gives +0
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cmp_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_delay.sv ====
`default_nettype none

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  payload_t d,
    output payload_t q
);

    payload_t stages [depth];

    // plain data chain, valids are tracked by the user
    always_ff @(posedge clk) begin
        stages[0] <= d;
        for (int i = 1; i < depth; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign q = stages[depth-1];

endmodule

`default_nettype wire

// ==== source/sgd_l1_update.sv ====
`default_nettype none

module sgd_l1_update import l1_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  l1_req_t  req,
    input  logic     req_valid,
    output l1_resp_t resp,
    output logic     resp_valid
);

    fp32_t corr;
    logic  corr_valid;

    l1_prox_step i_prox (
        .clk       (clk),
        .arst_n    (arst_n),
        .model     (req.model),
        .step      (req.step),
        .lambda    (req.lambda),
        .in_valid  (req_valid),
        .corr      (corr),
        .out_valid (corr_valid)
    );

    fp32_t model_d;
    idx_t  idx_d;
    fp32_t new_model;

    pipe_delay #(.payload_t(fp32_t), .depth(PROX_LAT)) i_model_dly (
        .clk (clk),
        .d   (req.model),
        .q   (model_d)
    );

    // index rides along for the whole pipeline
    pipe_delay #(.payload_t(idx_t), .depth(UPD_LAT)) i_idx_dly (
        .clk (clk),
        .d   (req.idx),
        .q   (idx_d)
    );

    fp_sub i_apply_sub (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (model_d),
        .b        (corr),
        .in_valid (corr_valid),
        .q        (new_model),
        .q_valid  (resp_valid)
    );

    assign resp = '{new_model: new_model, idx: idx_d};

endmodule

`default_nettype wire

// ==== sources.f ====
source/l1_pkg.sv
source/fp_sub.sv
source/fp_compare.sv
source/pipe_delay.sv
source/l1_prox_step.sv
source/sgd_l1_update.sv
test/sgd_l1_chk.sv
test/tb_sgd_l1_update.sv

// ==== test/sgd_l1_chk.sv ====
`default_nettype none

module sgd_l1_chk import l1_pkg::*; (
    input logic clk,
    input logic arst_n,
    input logic req_valid,
    input logic resp_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // each beat leaves exactly UPD_LAT cycles after it entered
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> ##UPD_LAT resp_valid)
        else $error("resp_valid missing %0d cycles after req_valid", UPD_LAT);

    a_no_orphan: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> $past(req_valid, UPD_LAT))
        else $error("resp_valid without a beat %0d cycles earlier", UPD_LAT);

    // pipeline stays empty while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |=> !resp_valid)
        else $error("resp_valid high during reset");

endmodule

`default_nettype wire

// ==== test/tb_sgd_l1_update.sv ====
`default_nettype none

module tb_sgd_l1_update import l1_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD  = 8;
    localparam int N_TESTS = 6;
    localparam int N_TBL   = 14;
    localparam int N_RAND  = 64;
    localparam int N_BEATS = 2 * N_TBL + N_RAND;
    // random gaps can double the beat time and each test drains the pipeline
    localparam int WATCHDOG_NS = (2 * N_BEATS + N_TESTS * (UPD_LAT + 4) + 5 + 40) * PERIOD;

    typedef struct packed {
        fp32_t      bits;
        idx_t       idx;
        logic [2:0] test;
        int         cyc;   // cycle count when the beat was driven
    } exp_t;

    logic     clk = 1'b0;
    logic     arst_n;
    l1_req_t  req;
    logic     req_valid;
    l1_resp_t resp;
    logic     resp_valid;

    int          cyc = 0;
    int          cur_test = 0;
    exp_t        exp_q [$];
    int          test_checks [N_TESTS];
    int          test_errors [N_TESTS];
    logic [15:0] lfsr_state = 16'd1591;

    string test_names [N_TESTS] = '{"reset_quiet", "upper", "lower", "dead_zone",
                                    "back_to_back", "random"};

    // model, step, lambda, expected new_model, test group
    real tbl_model  [N_TBL] = '{3.0, 1.25, 10.0, 0.5, -3.0, 0.5, -0.25, 0.0,
                                1.0, 1.0, 0.75, -0.5, 2.0, 0.0};
    real tbl_step   [N_TBL] = '{0.5, -0.5, 2.0, 0.0, 0.5, 2.0, 0.25, 4.0,
                                0.5, 1.5, 0.5, -0.25, 2.0, 0.0};
    real tbl_lambda [N_TBL] = '{1.0, 0.25, 0.125, 0.25, 1.0, 0.75, 0.125, 1.5,
                                0.5, 0.5, 1.0, 0.5, 0.0, 0.25};
    real tbl_expect [N_TBL] = '{1.5, 1.5, 7.875, 0.25, -2.5, -0.75, -0.375, -2.5,
                                0.0, 0.0, 0.0, 0.0, 0.0, 0.0};
    int  tbl_group  [N_TBL] = '{1, 1, 1, 1, 2, 2, 2, 2, 3, 3, 3, 3, 3, 3};

    sgd_l1_update i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_valid  (req_valid),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    bind sgd_l1_update sgd_l1_chk i_chk (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .resp_valid (resp_valid)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw(input int n, output int v);
        v = 0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | {31'd0, lfsr_state[0]};
        end
    endtask

    // exact for the dyadic values used here
    function automatic fp32_t to_fp32(input real r);
        logic [63:0] b;
        logic [10:0] e;
        fp32_t       f;
        b = $realtobits(r);
        e = b[62:52];
        if (b[62:0] == 63'd0) begin
            f = {b[63], 31'd0};
        end else begin
            f.sign     = b[63];
            f.exponent = 8'(e - 11'd896); // rebias 1023 to 127
            f.mantissa = b[51:29];
        end
        return f;
    endfunction

    function automatic real soft_threshold(input real d, input real l);
        if (d > l) begin
            return d - l;
        end else if (d < -l) begin
            return d + l;
        end
        return 0.0;
    endfunction

    task automatic check(input int test, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        test_checks[test]++;
        if (expected !== actual) begin
            $display("** Error %s %s: expected %h, actual %h",
                     test_names[test], what, expected, actual);
            test_errors[test]++;
        end
    endtask

    task automatic send(input int test, input real m, input real s, input real l,
                        input real expected, input idx_t idx);
        exp_t e;
        req       = '{model: to_fp32(m), step: to_fp32(s), lambda: to_fp32(l), idx: idx};
        req_valid = 1'b1;
        e.bits    = to_fp32(expected);
        e.idx     = idx;
        e.test    = 3'(test);
        e.cyc     = cyc;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        req_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int t);
        $display("test %s: %s, %0d checks, %0d errors", test_names[t],
                 (test_errors[t] == 0) ? "pass" : "FAIL", test_checks[t], test_errors[t]);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (exp_q.size() == 0) begin
            check(cur_test, "idle resp_valid", 32'd0, {31'd0, resp_valid});
        end else if (resp_valid === 1'b1) begin
            e = exp_q.pop_front();
            check(int'(e.test), "new_model", e.bits, resp.new_model);
            check(int'(e.test), "idx", 32'(e.idx), 32'(resp.idx));
            check(int'(e.test), "latency", 32'(UPD_LAT), 32'(cyc - e.cyc));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, responses still missing: %0d", exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int  v;
        int  passed;
        int  checks;
        int  errors;
        real m;
        real s;
        real l;
        req       = '0;
        req_valid = 1'b0;
        arst_n    = 1'b0;
        passed    = 0;
        checks    = 0;
        errors    = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (UPD_LAT + 4) @(posedge clk); // nothing may come out without input
        #1;
        finish_test(0);

        for (int t = 1; t <= 3; t++) begin
            cur_test = t;
            for (int i = 0; i < N_TBL; i++) begin
                if (tbl_group[i] == t) begin
                    send(t, tbl_model[i], tbl_step[i], tbl_lambda[i], tbl_expect[i], 10'(i));
                end
            end
            drain();
            finish_test(t);
        end

        cur_test = 4;
        for (int i = 0; i < N_TBL; i++) begin
            send(4, tbl_model[i], tbl_step[i], tbl_lambda[i], tbl_expect[i], 10'(200 + i));
        end
        drain();
        finish_test(4);

        cur_test = 5;
        for (int n = 0; n < N_RAND; n++) begin
            draw(2, v);
            if (v == 0) begin  // occasional bubble
                req_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            draw(8, v);
            m = real'((v >= 128) ? v - 256 : v) / 16.0;
            draw(8, v);
            s = real'((v >= 128) ? v - 256 : v) / 32.0;
            draw(5, v);
            l = real'(v) / 16.0;
            send(5, m, s, l, soft_threshold(m - s, l), 10'(512 + n));
        end
        drain();
        finish_test(5);

        for (int t = 0; t < N_TESTS; t++) begin
            checks += test_checks[t];
            errors += test_errors[t];
            if (test_errors[t] == 0) passed++;
        end
        $display("summary: %0d of %0d tests passed, %0d checks, %0d errors",
                 passed, N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
